// File: hw/ups_macros.svh
/*
 * Build-time constants for the zero-insertion interpolator.
 * Lane count, factor, field widths and APB register offsets.
 */
`ifndef UPS_MACROS_SVH
`define UPS_MACROS_SVH

`default_nettype none

`define UPS_LANES      4         // Channels, one lane each
`define UPS_FACTOR     4         // Interpolation factor
`define UPS_DATA_W     16        // Signed sample width
`define UPS_PHASE_W    2         // Per-lane phase field
`define UPS_CHAN_W     2         // Channel index
`define UPS_MAX_PHASE  ((1 << `UPS_PHASE_W) - 1)

// APB map
`define UPS_APB_AW     8
`define UPS_REG_CTRL   8'h00     // Bit 0 enable
`define UPS_REG_PHASE  8'h04     // 2 bits per lane
`define UPS_REG_STATUS 8'h08     // Sticky underrun, W1C

`default_nettype wire

`endif

// File: hw/ups_pkg.sv
/*
 * Shared types: sample, channel index, stream beats,
 * configuration word and per-lane holding slot.
 */
`include "ups_macros.svh"

`default_nettype none

package ups_pkg;

  typedef logic signed [`UPS_DATA_W-1:0] sample_t;
  typedef logic [`UPS_CHAN_W-1:0]        chan_t;

  // Input stream word
  typedef struct packed {
    chan_t   chan;
    sample_t data;
  } in_beat_t;

  // Output TDM stream word
  typedef struct packed {
    chan_t   chan;
    sample_t data;
  } out_beat_t;

  // Driven by the APB slave to every block
  typedef struct packed {
    logic                                    enable;
    logic [`UPS_LANES-1:0][`UPS_PHASE_W-1:0] phase;   // Lane 0 in low bits
  } ups_cfg_t;

  typedef struct packed {
    logic    valid;
    sample_t data;
  } hold_t;

endpackage

`default_nettype wire

// File: hw/ups_apb_regs.sv
/*
 * APB3 register slave, no wait states.
 * CTRL enable, PHASE per lane, STATUS sticky underrun flags.
 */
`include "ups_macros.svh"

`timescale 1ns/1ps
`default_nettype none

module ups_apb_regs (
  input  logic                   i_clk,
  input  logic                   i_rst_an,
  input  logic                   i_psel,
  input  logic                   i_penable,
  input  logic                   i_pwrite,
  input  logic [`UPS_APB_AW-1:0] i_paddr,
  input  logic [31:0]            i_pwdata,
  input  logic [`UPS_LANES-1:0]  i_underrun,     // One pulse per lane
  output logic [31:0]            o_prdata,
  output ups_pkg::ups_cfg_t      o_cfg
);

  logic                                    wr_en;
  logic                                    rd_en;
  logic                                    ctrl_en;
  logic [`UPS_LANES-1:0][`UPS_PHASE_W-1:0] phase;
  logic [`UPS_LANES-1:0]                   status;
  logic [`UPS_LANES-1:0]                   status_clr;

  // ------------------------------------------------------------------
  // Access decode
  // ------------------------------------------------------------------
  assign wr_en = i_psel & i_penable & i_pwrite;
  assign rd_en = i_psel & i_penable & ~i_pwrite;

  assign status_clr = (wr_en && i_paddr == `UPS_REG_STATUS) ?
                      i_pwdata[`UPS_LANES-1:0] : '0;

  always_ff @(posedge i_clk or negedge i_rst_an)
  begin
    if (!i_rst_an)
    begin
      ctrl_en <= 1'b0;
      phase   <= '0;
    end
    else if (wr_en)
    begin
      if (i_paddr == `UPS_REG_CTRL)
        ctrl_en <= i_pwdata[0];
      if (i_paddr == `UPS_REG_PHASE)
        phase <= i_pwdata[`UPS_LANES*`UPS_PHASE_W-1:0];
    end
  end

  // Set beats clear in the same cycle
  always_ff @(posedge i_clk or negedge i_rst_an)
  begin
    if (!i_rst_an)
      status <= '0;
    else
      status <= (status & ~status_clr) | i_underrun;
  end

  // ------------------------------------------------------------------
  // Read mux, valid in the access phase
  // ------------------------------------------------------------------
  always_comb
  begin
    o_prdata = '0;
    if (rd_en)
    begin
      case (i_paddr)
        `UPS_REG_CTRL:   o_prdata = 32'(ctrl_en);
        `UPS_REG_PHASE:  o_prdata = 32'(phase);
        `UPS_REG_STATUS: o_prdata = 32'(status);
        default:         o_prdata = '0;
      endcase
    end
  end

  assign o_cfg.enable = ctrl_en;
  assign o_cfg.phase  = phase;

endmodule

`default_nettype wire

// File: hw/ups_dispatch.sv
/*
 * Input stream handshake and one-deep holding slot per lane.
 */
`include "ups_macros.svh"

`timescale 1ns/1ps
`default_nettype none

module ups_dispatch (
  input  logic                  i_clk,
  input  logic                  i_rst_an,
  input  ups_pkg::ups_cfg_t     i_cfg,
  input  logic                  i_in_valid,
  input  ups_pkg::in_beat_t     i_in,
  input  logic [`UPS_LANES-1:0] i_take,         // Slot drained by lane
  output logic                  o_in_ready,
  output ups_pkg::hold_t        o_hold [`UPS_LANES]
);

  logic [`UPS_LANES-1:0] slot_valid;
  ups_pkg::sample_t      slot_data [`UPS_LANES];
  logic                  xfer;

  // Addressed slot empty, or being drained this cycle
  assign o_in_ready = i_cfg.enable &
                      (~slot_valid[i_in.chan] | i_take[i_in.chan]);
  assign xfer       = i_in_valid & o_in_ready;

  always_ff @(posedge i_clk or negedge i_rst_an)
  begin
    if (!i_rst_an)
      slot_valid <= '0;
    else if (!i_cfg.enable)
      slot_valid <= '0;                          // Flush while disabled
    else
    begin
      for (int l = 0; l < `UPS_LANES; l++)
      begin
        if (xfer && i_in.chan == ups_pkg::chan_t'(l))
          slot_valid[l] <= 1'b1;                 // Refill wins over take
        else if (i_take[l])
          slot_valid[l] <= 1'b0;
      end
    end
  end

  // Sample payload
  always_ff @(posedge i_clk)
  begin
    for (int l = 0; l < `UPS_LANES; l++)
    begin
      if (xfer && i_in.chan == ups_pkg::chan_t'(l))
        slot_data[l] <= i_in.data;
    end
  end

  always_comb
  begin
    for (int l = 0; l < `UPS_LANES; l++)
    begin
      o_hold[l].valid = slot_valid[l];
      o_hold[l].data  = slot_data[l];
    end
  end

endmodule

`default_nettype wire

// File: hw/ups_zero_stuff_lane.sv
/*
 * One interpolator lane: modulo-factor load counter,
 * zero-insertion mux and programmable phase delay taps.
 */
`include "ups_macros.svh"

`timescale 1ns/1ps
`default_nettype none

module ups_zero_stuff_lane #(
  parameter int LANE_ID = 0                    // Selects the phase field
) (
  input  logic              i_clk,
  input  logic              i_rst_an,
  input  ups_pkg::ups_cfg_t i_cfg,
  input  logic              i_tick,
  input  ups_pkg::hold_t    i_hold,
  output logic              o_take,
  output logic              o_underrun,
  output ups_pkg::sample_t  o_data
);

  localparam int CNT_W = (`UPS_FACTOR > 1) ? $clog2(`UPS_FACTOR) : 1;
  localparam int NTAPS = `UPS_MAX_PHASE + 1;

  logic [CNT_W-1:0] load_cnt;
  logic             step;
  logic             load;
  ups_pkg::sample_t stuffed;
  ups_pkg::sample_t taps [NTAPS];

  // ------------------------------------------------------------------
  // Load decision and zero insertion
  // ------------------------------------------------------------------
  assign step       = i_tick & i_cfg.enable;   // Ticks ignored when off
  assign load       = (load_cnt == '0);
  assign o_take     = step & load & i_hold.valid;
  assign o_underrun = step & load & ~i_hold.valid;
  assign stuffed    = o_take ? i_hold.data : '0;

  // Counter restarts at 0, so the first tick after enable loads
  always_ff @(posedge i_clk or negedge i_rst_an)
  begin
    if (!i_rst_an)
      load_cnt <= '0;
    else if (!i_cfg.enable)
      load_cnt <= '0;
    else if (step)
    begin
      if (load_cnt == CNT_W'(`UPS_FACTOR - 1))
        load_cnt <= '0;
      else
        load_cnt <= load_cnt + 1'b1;
    end
  end

  // ------------------------------------------------------------------
  // Phase delay chain, tap n holds stuffed value k-n
  // ------------------------------------------------------------------
  always_ff @(posedge i_clk or negedge i_rst_an)
  begin
    if (!i_rst_an)
    begin
      for (int t = 0; t < NTAPS; t++)
        taps[t] <= '0;
    end
    else if (!i_cfg.enable)
    begin
      for (int t = 0; t < NTAPS; t++)
        taps[t] <= '0;
    end
    else if (step)
    begin
      taps[0] <= stuffed;
      for (int t = 1; t < NTAPS; t++)
        taps[t] <= taps[t-1];
    end
  end

  assign o_data = taps[i_cfg.phase[LANE_ID]];  // Phase picks the tap

endmodule

`default_nettype wire

// File: hw/ups_tdm_collect.sv
/*
 * Snapshot of all lane outputs one cycle after each tick,
 * shifted out as a channel-tagged TDM burst.
 */
`include "ups_macros.svh"

`timescale 1ns/1ps
`default_nettype none

module ups_tdm_collect (
  input  logic               i_clk,
  input  logic               i_rst_an,
  input  ups_pkg::ups_cfg_t  i_cfg,
  input  logic               i_tick,
  input  ups_pkg::sample_t   i_lane_data [`UPS_LANES],
  output logic               o_out_valid,
  output ups_pkg::out_beat_t o_out
);

  logic             tick_d;                    // Lanes settled after this
  logic             busy;
  ups_pkg::chan_t   beat_cnt;
  ups_pkg::sample_t bank [`UPS_LANES];

  always_ff @(posedge i_clk or negedge i_rst_an)
  begin
    if (!i_rst_an)
    begin
      tick_d   <= 1'b0;
      busy     <= 1'b0;
      beat_cnt <= '0;
    end
    else if (!i_cfg.enable)
    begin
      tick_d   <= 1'b0;
      busy     <= 1'b0;
      beat_cnt <= '0;
    end
    else
    begin
      tick_d <= i_tick;
      if (tick_d)
      begin
        busy     <= 1'b1;                      // Burst starts next cycle
        beat_cnt <= '0;
      end
      else if (busy)
      begin
        beat_cnt <= beat_cnt + 1'b1;
        if (beat_cnt == ups_pkg::chan_t'(`UPS_LANES - 1))
          busy <= 1'b0;
      end
    end
  end

  // Bank loads on capture, then shifts toward slot 0
  always_ff @(posedge i_clk)
  begin
    if (tick_d)
      bank <= i_lane_data;
    else if (busy)
    begin
      for (int i = 0; i < `UPS_LANES - 1; i++)
        bank[i] <= bank[i+1];
    end
  end

  assign o_out_valid = busy;
  assign o_out.chan  = beat_cnt;
  assign o_out.data  = bank[0];

endmodule

`default_nettype wire

// File: hw/ups_top.sv
/*
 * Four-channel zero-insertion interpolator front end.
 * APB registers, dispatcher, lane array and TDM collector.
 */
`include "ups_macros.svh"

`timescale 1ns/1ps
`default_nettype none

module ups_top (
  input  logic                   i_clk,
  input  logic                   i_rst_an,

  // APB slave
  input  logic                   i_psel,
  input  logic                   i_penable,
  input  logic                   i_pwrite,
  input  logic [`UPS_APB_AW-1:0] i_paddr,
  input  logic [31:0]            i_pwdata,
  output logic [31:0]            o_prdata,

  // Output rate strobe
  input  logic                   i_tick,

  // Input stream
  input  logic                   i_in_valid,
  input  ups_pkg::in_beat_t      i_in,
  output logic                   o_in_ready,

  // TDM output, no back-pressure
  output logic                   o_out_valid,
  output ups_pkg::out_beat_t     o_out
);

  ups_pkg::ups_cfg_t     cfg;
  logic [`UPS_LANES-1:0] underrun;
  logic [`UPS_LANES-1:0] take;
  ups_pkg::hold_t        hold [`UPS_LANES];
  ups_pkg::sample_t      lane_data [`UPS_LANES];

  ups_apb_regs ups_apb_regs_inst (
    .i_clk      (i_clk),
    .i_rst_an   (i_rst_an),
    .i_psel     (i_psel),
    .i_penable  (i_penable),
    .i_pwrite   (i_pwrite),
    .i_paddr    (i_paddr),
    .i_pwdata   (i_pwdata),
    .i_underrun (underrun),
    .o_prdata   (o_prdata),
    .o_cfg      (cfg)
  );

  ups_dispatch ups_dispatch_inst (
    .i_clk      (i_clk),
    .i_rst_an   (i_rst_an),
    .i_cfg      (cfg),
    .i_in_valid (i_in_valid),
    .i_in       (i_in),
    .i_take     (take),
    .o_in_ready (o_in_ready),
    .o_hold     (hold)
  );

  // ------------------------------------------------------------------
  // Lane array
  // ------------------------------------------------------------------
  for (genvar l = 0; l < `UPS_LANES; l++)
  begin : g_lane
    ups_zero_stuff_lane #(
      .LANE_ID (l)
    ) ups_zero_stuff_lane_inst (
      .i_clk      (i_clk),
      .i_rst_an   (i_rst_an),
      .i_cfg      (cfg),
      .i_tick     (i_tick),
      .i_hold     (hold[l]),
      .o_take     (take[l]),
      .o_underrun (underrun[l]),
      .o_data     (lane_data[l])
    );
  end

  ups_tdm_collect ups_tdm_collect_inst (
    .i_clk       (i_clk),
    .i_rst_an    (i_rst_an),
    .i_cfg       (cfg),
    .i_tick      (i_tick),
    .i_lane_data (lane_data),
    .o_out_valid (o_out_valid),
    .o_out       (o_out)
  );

endmodule

`default_nettype wire

// File: verif/ups_asserts.sv
/*
 * Stream protocol checks bound into ups_top:
 * stalled input hold, TDM burst framing, tick spacing.
 */
`include "ups_macros.svh"

`timescale 1ns/1ps
`default_nettype none

module ups_asserts (
  input  logic               i_clk,
  input  logic               i_rst_an,
  input  logic               i_tick,
  input  logic               i_in_valid,
  input  ups_pkg::in_beat_t  i_in,
  input  logic               i_in_ready,
  input  logic               i_out_valid,
  input  ups_pkg::out_beat_t i_out
);

  localparam ups_pkg::chan_t LAST = ups_pkg::chan_t'(`UPS_LANES - 1);

  int unsigned n_hold_err  = 0;
  int unsigned n_start_err = 0;
  int unsigned n_step_err  = 0;
  int unsigned n_end_err   = 0;
  int unsigned n_tick_err  = 0;
  int unsigned n_fail;

  assign n_fail = n_hold_err + n_start_err + n_step_err + n_end_err + n_tick_err;

  // Source keeps the beat while stalled
  a_hold: assert property (@(posedge i_clk) disable iff (!i_rst_an)
    i_in_valid && !i_in_ready |=> !i_in_valid || $stable(i_in))
  else
  begin
    n_hold_err++;
    $error("Input beat changed while stalled");
  end

  // ------------------------------------------------------------------
  // Burst framing, chan 0 first then increasing
  // ------------------------------------------------------------------
  a_start: assert property (@(posedge i_clk) disable iff (!i_rst_an)
    $rose(i_out_valid) |-> i_out.chan == '0)
  else
  begin
    n_start_err++;
    $error("Burst does not start at channel 0");
  end

  a_step: assert property (@(posedge i_clk) disable iff (!i_rst_an)
    i_out_valid && i_out.chan != LAST |=>
      i_out_valid && i_out.chan == ups_pkg::chan_t'($past(i_out.chan) + 1'b1))
  else
  begin
    n_step_err++;
    $error("Burst ended early or skipped a channel");
  end

  a_end: assert property (@(posedge i_clk) disable iff (!i_rst_an)
    i_out_valid && i_out.chan == LAST |=> !i_out_valid)
  else
  begin
    n_end_err++;
    $error("Burst longer than the lane count");
  end

  a_tick: assert property (@(posedge i_clk) disable iff (!i_rst_an)
    i_tick |-> !i_out_valid)
  else
  begin
    n_tick_err++;
    $error("Tick arrived during a burst");
  end

endmodule

bind ups_top ups_asserts ups_asserts_inst (
  .i_clk       (i_clk),
  .i_rst_an    (i_rst_an),
  .i_tick      (i_tick),
  .i_in_valid  (i_in_valid),
  .i_in        (i_in),
  .i_in_ready  (o_in_ready),
  .i_out_valid (o_out_valid),
  .i_out       (o_out)
);

`default_nettype wire

// File: verif/ups_tb.sv
/*
 * Table-driven testbench for ups_top: clock and reset, APB tasks,
 * stream feeder, reference model, output monitor and watchdog.
 */
`include "ups_macros.svh"

`timescale 1ns/1ps
`default_nettype none

module ups_tb;

  // One row per test
  typedef struct packed {
    logic                                en;
    logic [`UPS_LANES*`UPS_PHASE_W-1:0] phase;       // Lane 0 in low bits
    logic [7:0]                          n_ticks;
    logic                                skip_en;     // Leave one lane unfed
    logic [1:0]                          skip_lane;
  } row_t;

  localparam int N_ROWS = 6;
  localparam row_t ROWS [N_ROWS] = '{
    '{1'b1, 8'h00, 8'd16, 1'b0, 2'd0},   // All phases 0
    '{1'b1, 8'hE4, 8'd20, 1'b0, 2'd0},   // Lane n delayed by n ticks
    '{1'b1, 8'h1B, 8'd16, 1'b1, 2'd2},   // Lane 2 starved
    '{1'b0, 8'h00, 8'd12, 1'b0, 2'd0},   // Disabled, no bursts
    '{1'b1, 8'h4E, 8'd16, 1'b1, 2'd0},
    '{1'b1, 8'h00, 8'd12, 1'b0, 2'd0}
  };

  logic                   clk;
  logic                   rst_an;
  logic                   psel;
  logic                   penable;
  logic                   pwrite;
  logic [`UPS_APB_AW-1:0] paddr;
  logic [31:0]            pwdata;
  logic [31:0]            prdata;
  logic                   tick;
  logic                   in_valid;
  ups_pkg::in_beat_t      in_beat;
  logic                   in_ready;
  logic                   out_valid;
  ups_pkg::out_beat_t     out_beat;

  // Reference model state
  logic                   slot_full [`UPS_LANES];
  ups_pkg::sample_t       slot_val  [`UPS_LANES];
  ups_pkg::sample_t       hist      [`UPS_LANES][64];  // Stuffed value per tick
  int                     n_tick;                      // Ticks since enable
  logic [`UPS_LANES-1:0]  sticky;
  ups_pkg::out_beat_t     exp_q [$];

  ups_top ups_top_inst (
    .i_clk       (clk),
    .i_rst_an    (rst_an),
    .i_psel      (psel),
    .i_penable   (penable),
    .i_pwrite    (pwrite),
    .i_paddr     (paddr),
    .i_pwdata    (pwdata),
    .o_prdata    (prdata),
    .i_tick      (tick),
    .i_in_valid  (in_valid),
    .i_in        (in_beat),
    .o_in_ready  (in_ready),
    .o_out_valid (out_valid),
    .o_out       (out_beat)
  );

  initial
  begin : clock_gen
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ------------------------------------------------------------------
  // Failure reporting and compare tasks
  // ------------------------------------------------------------------
  task automatic end_with_failure();
    $display("Simulation finished: FAIL");
    $fatal(1, "Run stopped at the first failure");
  endtask

  task automatic check_beat(input ups_pkg::out_beat_t got, input ups_pkg::out_beat_t exp);
    if (got !== exp)
    begin
      $display("[ERROR] %0t ns: beat chan %0d data %0d, expected chan %0d data %0d",
               $time, got.chan, got.data, exp.chan, exp.data);
      end_with_failure();
    end
  endtask

  task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp)
    begin
      $display("[ERROR] %0t ns: %s read 0x%08h, expected 0x%08h", $time, what, got, exp);
      end_with_failure();
    end
  endtask

  task automatic check_ready(input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("[ERROR] %0t ns: ready %b for chan %0d, expected %b",
               $time, got, in_beat.chan, exp);
      end_with_failure();
    end
  endtask

  // ------------------------------------------------------------------
  // APB master
  // ------------------------------------------------------------------
  task automatic apb_write(input logic [`UPS_APB_AW-1:0] addr, input logic [31:0] data);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(negedge clk);
    penable = 1'b1;                    // Access phase, no wait states
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input logic [`UPS_APB_AW-1:0] addr, output logic [31:0] data);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(negedge clk);
    penable = 1'b1;
    #1;
    data    = prdata;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic read_check(input logic [`UPS_APB_AW-1:0] addr, input logic [31:0] exp,
                            input string what);
    logic [31:0] rd;
    apb_read(addr, rd);
    check_word(rd, exp, what);
  endtask

  // ------------------------------------------------------------------
  // Reference model
  // ------------------------------------------------------------------
  task automatic model_clear();
    n_tick = 0;
    for (int l = 0; l < `UPS_LANES; l++)
      slot_full[l] = 1'b0;
  endtask

  // One enabled tick: load or zero, then pick the delayed value
  task automatic model_tick(input logic [`UPS_LANES*`UPS_PHASE_W-1:0] phase);
    ups_pkg::out_beat_t b;
    int                 ph;
    for (int l = 0; l < `UPS_LANES; l++)
    begin
      hist[l][n_tick] = '0;
      if (n_tick % `UPS_FACTOR == 0)
      begin
        if (slot_full[l])
          hist[l][n_tick] = slot_val[l];
        else
          sticky[l] = 1'b1;            // Underrun stuffs a zero
        slot_full[l] = 1'b0;
      end
      ph     = int'(phase[l*`UPS_PHASE_W +: `UPS_PHASE_W]);
      b.chan = ups_pkg::chan_t'(l);
      b.data = (n_tick >= ph) ? hist[l][n_tick-ph] : '0;
      exp_q.push_back(b);
    end
    n_tick++;
  endtask

  function automatic ups_pkg::chan_t next_chan(input ups_pkg::chan_t c, input row_t row);
    ups_pkg::chan_t n;
    n = c + 1'b1;
    if (row.skip_en && n == row.skip_lane)
      n = n + 1'b1;
    return n;
  endfunction

  // Round-robin feeder plus a tick every 8 cycles
  task automatic run_row(input row_t row);
    ups_pkg::chan_t cur;
    logic           have_beat;
    logic           exp_rdy;
    cur       = next_chan(ups_pkg::chan_t'(`UPS_LANES - 1), row);
    have_beat = 1'b0;
    for (int cyc = 0; cyc < 8 * int'(row.n_ticks); cyc++)
    begin
      @(negedge clk);
      tick = (cyc % 8 == 7);           // Slots filled before first tick
      if (!have_beat)
      begin
        in_beat.chan = cur;
        in_beat.data = ups_pkg::sample_t'($urandom);
        cur          = next_chan(cur, row);
        have_beat    = 1'b1;
      end
      in_valid = 1'b1;
      #1;
      exp_rdy = row.en && (!slot_full[in_beat.chan] ||
                           (tick && n_tick % `UPS_FACTOR == 0));
      check_ready(in_ready, exp_rdy);
      if (tick && row.en)
        model_tick(row.phase);
      if (exp_rdy)
      begin
        slot_full[in_beat.chan] = 1'b1;   // Refill after the take
        slot_val[in_beat.chan]  = in_beat.data;
        have_beat               = 1'b0;
      end
    end
    @(negedge clk);
    tick     = 1'b0;
    in_valid = 1'b0;
  endtask

  // Every output beat must match the next predicted one
  initial
  begin : out_monitor
    ups_pkg::out_beat_t exp_b;
    forever
    begin
      @(negedge clk);
      if (rst_an && out_valid)
      begin
        if (exp_q.size() == 0)
        begin
          $display("Output beat at %0t ns with no enabled tick behind it", $time);
          end_with_failure();
        end
        exp_b = exp_q.pop_front();
        check_beat(out_beat, exp_b);
      end
    end
  end

  initial
  begin : watchdog
    int limit;
    int cycles;
    limit = 0;
    for (int r = 0; r < N_ROWS; r++)
      limit += int'(ROWS[r].n_ticks);
    limit  = 2 * (limit * 8) + 200;
    cycles = 0;
    forever
    begin
      @(posedge clk);
      cycles++;
      if (ups_top_inst.ups_asserts_inst.n_fail != 0)
      begin
        $display("Protocol assertion failed before %0t ns", $time);
        end_with_failure();
      end
      if (cycles > limit)
      begin
        $display("Timeout: test sequence still running after %0d cycles", cycles);
        end_with_failure();
      end
    end
  end

  // ------------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------------
  initial
  begin : main_seq
    row_t row;
    void'($urandom(63749));
    rst_an   = 1'b0;
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    paddr    = '0;
    pwdata   = '0;
    tick     = 1'b0;
    in_valid = 1'b0;
    in_beat  = '0;
    sticky   = '0;
    model_clear();
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_an = 1'b1;

    read_check(`UPS_REG_CTRL, 32'd0, "CTRL after reset");
    read_check(`UPS_REG_PHASE, 32'd0, "PHASE after reset");
    read_check(`UPS_REG_STATUS, 32'd0, "STATUS after reset");
    check_ready(in_ready, 1'b0);

    for (int r = 0; r < N_ROWS; r++)
    begin
      row = ROWS[r];
      apb_write(`UPS_REG_CTRL, 32'd0);               // Flush lanes and slots
      model_clear();
      apb_write(`UPS_REG_PHASE, 32'(row.phase));
      apb_write(`UPS_REG_CTRL, 32'(row.en));
      read_check(`UPS_REG_PHASE, 32'(row.phase), "PHASE");
      read_check(`UPS_REG_CTRL, 32'(row.en), "CTRL");
      run_row(row);
      repeat (8) @(negedge clk);                     // Last burst drains
      if (exp_q.size() != 0)
      begin
        $display("Row %0d ended with %0d predicted beats never seen", r, exp_q.size());
        end_with_failure();
      end
      read_check(`UPS_REG_STATUS, 32'(sticky), "STATUS");
      apb_write(`UPS_REG_STATUS, 32'hF);
      sticky = '0;
      read_check(`UPS_REG_STATUS, 32'd0, "STATUS after clear");
    end

    if (ups_top_inst.ups_asserts_inst.n_fail != 0)
    begin
      $display("Protocol assertions failed %0d times",
               ups_top_inst.ups_asserts_inst.n_fail);
      end_with_failure();
    end
    else
    begin
      $display("Simulation finished: PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: src.f
+incdir+hw
hw/ups_pkg.sv
hw/ups_apb_regs.sv
hw/ups_dispatch.sv
hw/ups_zero_stuff_lane.sv
hw/ups_tdm_collect.sv
hw/ups_top.sv
verif/ups_asserts.sv
verif/ups_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the interpolator testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module ups_tb \
  --Mdir obj_dir -o ups_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "Verilator build failed, see build.log"
  exit 1
fi

# Keep running past assertion errors so the testbench reports the result
./obj_dir/ups_sim +verilator+error+limit+100 > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
  echo "Result: FAIL"
  exit 1
fi

if [ $sim_status -ne 0 ]; then
  echo "Simulator exited with status $sim_status"
  exit 1
fi

echo "Result: PASS"
exit 0
